// File: logic/simd_alu_config.svh
// lane count and fixed lane width macros for the simd alu
`default_nettype none

`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

// number of parallel lanes
`define SIMD_LANES 4

// lane width, tied to the 8-bit prefix adder tree
`define SIMD_LANE_WIDTH 8

`endif

`default_nettype wire

// File: logic/simd_alu_pkg.sv
// simd alu package: lane word, packed word, lane mask and opcode types
`include "simd_alu_config.svh"
`default_nettype none

package simd_alu_pkg;

    // one lane operand or result
    typedef logic [`SIMD_LANE_WIDTH-1:0] lane_word_t;

    // all lanes side by side, lane 0 in the low bits
    typedef logic [`SIMD_LANES*`SIMD_LANE_WIDTH-1:0] packed_word_t;

    // one bit per lane
    typedef logic [`SIMD_LANES-1:0] lane_mask_t;

    // operation code, shared by all lanes
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t OP_ADD = 2'd0;
    localparam alu_op_t OP_SUB = 2'd1;
    localparam alu_op_t OP_AND = 2'd2;
    localparam alu_op_t OP_OR  = 2'd3;

endpackage

`default_nettype wire

// File: logic/lane_bus_if.sv
// lane bus interface: per-lane valid, opcode and operands with dispatch and lane modports
`timescale 1ns/10ps
`default_nettype none

interface lane_bus_if
    import simd_alu_pkg::*;
();

    // lane acts only while valid is high
    logic       valid;
    alu_op_t    op;
    lane_word_t a;
    lane_word_t b;

    // driven by the dispatcher register stage
    modport dispatch (
        output valid,
        output op,
        output a,
        output b
    );

    // sampled by one lane alu
    modport lane (
        input valid,
        input op,
        input a,
        input b
    );

endinterface

`default_nettype wire

// File: logic/brent_kung_adder.sv
// 8-bit brent-kung prefix adder, sum modulo 256 without carry in or out
`timescale 1ns/10ps
`default_nettype none

module brent_kung_adder
    import simd_alu_pkg::*;
(
    input  lane_word_t a,
    input  lane_word_t b,
    output lane_word_t sum
);

    // bit generate, top bit only feeds a carry out and is dropped
    logic [6:0] g;
    // bit propagate, also the half sum
    lane_word_t p;

    // level 1 group terms over bit pairs
    logic g_1_0;
    logic g_3_2;
    logic p_3_2;
    logic g_5_4;
    logic p_5_4;

    // level 2 group term over bits 3..0
    logic g_3_0;

    // carry out of each bit position 0..6
    logic [6:0] c;

    assign g = a[6:0] & b[6:0];
    assign p = a ^ b;

    // level 1
    assign g_1_0 = g[1] | (p[1] & g[0]);
    assign g_3_2 = g[3] | (p[3] & g[2]);
    assign p_3_2 = p[3] & p[2];
    assign g_5_4 = g[5] | (p[5] & g[4]);
    assign p_5_4 = p[5] & p[4];

    // level 2
    assign g_3_0 = g_3_2 | (p_3_2 & g_1_0);

    // carries straight off the up-sweep
    assign c[0] = g[0];
    assign c[1] = g_1_0;
    assign c[3] = g_3_0;

    // level 3, down-sweep into the upper pair
    assign c[5] = g_5_4 | (p_5_4 & g_3_0);

    // even positions take one more black cell from the carry below
    assign c[2] = g[2] | (p[2] & c[1]);
    assign c[4] = g[4] | (p[4] & c[3]);
    assign c[6] = g[6] | (p[6] & c[5]);

    // bit 0 sees no carry in
    assign sum[0]   = p[0];
    assign sum[7:1] = p[7:1] ^ c[6:0];

endmodule

`default_nettype wire

// File: logic/alu_lane.sv
// one registered lane alu: add, subtract, and, or selected by opcode
`timescale 1ns/10ps
`default_nettype none

module alu_lane
    import simd_alu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    lane_bus_if.lane     bus,
    output logic         lane_valid,
    output lane_word_t   lane_result
);

    lane_word_t b_neg;
    lane_word_t add_sum;
    lane_word_t sub_diff;
    lane_word_t and_res;
    lane_word_t or_res;
    lane_word_t result_next;

    // a + b
    brent_kung_adder add_i (
        .a   (bus.a),
        .b   (bus.b),
        .sum (add_sum)
    );

    // a - b as a plus two's complement of b
    assign b_neg = ~bus.b + lane_word_t'(1);

    brent_kung_adder sub_i (
        .a   (bus.a),
        .b   (b_neg),
        .sum (sub_diff)
    );

    assign and_res = bus.a & bus.b;
    assign or_res  = bus.a | bus.b;

    // result select
    always_comb begin
        case (bus.op)
            OP_ADD:  result_next = add_sum;
            OP_SUB:  result_next = sub_diff;
            OP_AND:  result_next = and_res;
            OP_OR:   result_next = or_res;
            default: result_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= bus.valid;
        end
    end

    // result only loads for an active lane
    always_ff @(posedge clk) begin
        if (bus.valid) begin
            lane_result <= result_next;
        end
    end

    // an active lane always presents a known result
    lane_result_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        lane_valid |-> !$isunknown(lane_result)
    );

endmodule

`default_nettype wire

// File: logic/operand_dispatch.sv
// dispatch register stage: opcode broadcast, operand slicing and masked lane valids
`timescale 1ns/10ps
`include "simd_alu_config.svh"
`default_nettype none

module operand_dispatch
    import simd_alu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  alu_op_t       op,
    input  lane_mask_t    lane_mask,
    input  packed_word_t  a,
    input  packed_word_t  b,
    lane_bus_if.dispatch  lanes [`SIMD_LANES],
    output logic          dispatch_valid
);

    lane_mask_t   lane_valid_q;
    alu_op_t      op_q;
    packed_word_t a_q;
    packed_word_t b_q;

    // operation valid runs even with an all-zero mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
            lane_valid_q   <= '0;
        end else begin
            dispatch_valid <= in_valid;
            lane_valid_q   <= in_valid ? lane_mask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    // lane i gets bits [i*8 +: 8]
    for (genvar i = 0; i < `SIMD_LANES; i++) begin : g_lane
        assign lanes[i].valid = lane_valid_q[i];
        assign lanes[i].op    = op_q;
        assign lanes[i].a     = a_q[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH];
        assign lanes[i].b     = b_q[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH];
    end

    // lane valids must be known once out of reset, lanes and collector rely on them
    lane_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({dispatch_valid, lane_valid_q})
    );

endmodule

`default_nettype wire

// File: logic/result_collect.sv
// collect register stage: lane packing, idle lane zeroing and per-lane zero flags
`timescale 1ns/10ps
`include "simd_alu_config.svh"
`default_nettype none

module result_collect
    import simd_alu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         op_valid,
    input  lane_mask_t   lane_valid,
    input  lane_word_t   lane_result [`SIMD_LANES],
    output logic         out_valid,
    output packed_word_t result,
    output lane_mask_t   zero_flags
);

    // op_valid delayed to line up with the lane stage
    logic         op_valid_q;
    packed_word_t result_next;
    lane_mask_t   zero_next;

    always_comb begin
        for (int i = 0; i < `SIMD_LANES; i++) begin
            // idle lanes read 0 and never flag zero
            result_next[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH] =
                lane_valid[i] ? lane_result[i] : '0;
            zero_next[i] = lane_valid[i] && (lane_result[i] == '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid_q <= 1'b0;
            out_valid  <= 1'b0;
            result     <= '0;
            zero_flags <= '0;
        end else begin
            op_valid_q <= op_valid;
            out_valid  <= op_valid_q;
            result     <= result_next;
            zero_flags <= zero_next;
        end
    end

    // lane data only ever shows up together with out_valid
    outputs_only_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> (result == '0 && zero_flags == '0)
    );

endmodule

`default_nettype wire

// File: logic/simd_alu_top.sv
// simd alu top: dispatcher, generated lane alus and result collector
`timescale 1ns/10ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_top
    import simd_alu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  alu_op_t      op,
    input  lane_mask_t   lane_mask,
    input  packed_word_t a,
    input  packed_word_t b,
    output logic         out_valid,
    output packed_word_t result,
    output lane_mask_t   zero_flags
);

    lane_bus_if lane_bus [`SIMD_LANES] ();

    logic       dispatch_valid;
    lane_mask_t lane_valid;
    lane_word_t lane_result [`SIMD_LANES];

    operand_dispatch dispatch_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .op             (op),
        .lane_mask      (lane_mask),
        .a              (a),
        .b              (b),
        .lanes          (lane_bus),
        .dispatch_valid (dispatch_valid)
    );

    for (genvar i = 0; i < `SIMD_LANES; i++) begin : g_lane
        alu_lane lane_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .bus         (lane_bus[i]),
            .lane_valid  (lane_valid[i]),
            .lane_result (lane_result[i])
        );
    end

    result_collect collect_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (dispatch_valid),
        .lane_valid  (lane_valid),
        .lane_result (lane_result),
        .out_valid   (out_valid),
        .result      (result),
        .zero_flags  (zero_flags)
    );

endmodule

`default_nettype wire

// File: sim/simd_alu_checker.sv
// simd alu checker: expected value queues, in-order compare, latency check and counts
`timescale 1ns/10ps
`default_nettype none

module simd_alu_checker
    import simd_alu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         out_valid,
    input  packed_word_t result,
    input  lane_mask_t   zero_flags,
    input  logic         exp_valid,
    input  packed_word_t exp_result,
    input  lane_mask_t   exp_zero,
    input  logic         summary,
    output int           pending,
    output int           error_count
);

    // edges from the input sample to the edge that sees out_valid
    localparam int LATENCY = 3;

    packed_word_t result_q [$];
    lane_mask_t   zero_q [$];
    int           cycle_q [$];
    int           cycle;
    int           test_count;
    int           pass_count;
    int           errors;
    logic         seen_output;
    logic         reported;

    initial begin
        cycle       = 0;
        test_count  = 0;
        pass_count  = 0;
        errors      = 0;
        seen_output = 1'b0;
        reported    = 1'b0;
        pending     = 0;
        error_count = 0;
    end

    always @(posedge clk) begin
        logic         ok;
        packed_word_t er;
        lane_mask_t   ez;
        int           ec;
        cycle++;
        if (rst_n) begin
            if (out_valid) begin
                seen_output = 1'b1;
                if (result_q.size() == 0) begin
                    $display("out_valid high at cycle %0d with no operation pending", cycle);
                    errors++;
                end else begin
                    er = result_q.pop_front();
                    ez = zero_q.pop_front();
                    ec = cycle_q.pop_front();
                    test_count++;
                    ok = 1'b1;
                    if (result !== er) begin
                        $display("MISMATCH result: expected 0x%h, got 0x%h", er, result);
                        ok = 1'b0;
                    end
                    if (zero_flags !== ez) begin
                        $display("MISMATCH zero_flags: expected 0x%h, got 0x%h", ez, zero_flags);
                        ok = 1'b0;
                    end
                    if (cycle != ec + LATENCY) begin
                        $display("test %0d came out at cycle %0d instead of cycle %0d",
                                 test_count, cycle, ec + LATENCY);
                        ok = 1'b0;
                    end
                    if (ok) begin
                        pass_count++;
                    end else begin
                        errors++;
                    end
                    $display("test %0d: result 0x%h zero_flags 0x%h %s",
                             test_count, result, zero_flags, ok ? "ok" : "failed");
                end
            end else if (!seen_output && (result !== '0 || zero_flags !== '0)) begin
                // reset values hold until the first operation comes out
                $display("result or zero_flags not 0 after reset at cycle %0d", cycle);
                errors++;
            end
            if (exp_valid) begin
                result_q.push_back(exp_result);
                zero_q.push_back(exp_zero);
                cycle_q.push_back(cycle);
            end
            if (summary && !reported) begin
                reported = 1'b1;
                if (result_q.size() != 0) begin
                    $display("%0d expected results never came out of the DUT", result_q.size());
                    errors += result_q.size();
                end
                $display("tests %0d, passed %0d, errors %0d", test_count, pass_count, errors);
            end
        end
        pending     <= result_q.size();
        error_count <= errors;
    end

endmodule

`default_nettype wire

// File: sim/simd_alu_tb.sv
// simd alu testbench: clock, reset, lfsr, stimulus table, reference model and dut
`timescale 1ns/10ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_tb
    import simd_alu_pkg::*;
();

    localparam int NUM_FIXED     = 11;
    localparam int NUM_RANDOM    = 24;
    localparam int DRAIN_TIMEOUT = 50;

    typedef struct packed {
        alu_op_t      op;
        lane_mask_t   mask;
        packed_word_t a;
        packed_word_t b;
        packed_word_t exp_result;
        lane_mask_t   exp_zero;
    } stim_row_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    alu_op_t      op;
    lane_mask_t   lane_mask;
    packed_word_t a;
    packed_word_t b;
    logic         out_valid;
    packed_word_t result;
    lane_mask_t   zero_flags;
    logic         exp_valid;
    packed_word_t exp_result;
    lane_mask_t   exp_zero;
    logic         summary;
    int           pending;
    int           error_count;
    logic [15:0]  lfsr_state;
    stim_row_t    stim_table [$];

    simd_alu_top simd_alu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .op         (op),
        .lane_mask  (lane_mask),
        .a          (a),
        .b          (b),
        .out_valid  (out_valid),
        .result     (result),
        .zero_flags (zero_flags)
    );

    simd_alu_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_valid   (out_valid),
        .result      (result),
        .zero_flags  (zero_flags),
        .exp_valid   (exp_valid),
        .exp_result  (exp_result),
        .exp_zero    (exp_zero),
        .summary     (summary),
        .pending     (pending),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // per lane: sum or difference modulo 256, and, or; idle lanes give 0
    function automatic stim_row_t apply_reference(input stim_row_t row);
        lane_word_t x;
        lane_word_t y;
        lane_word_t r;
        for (int i = 0; i < `SIMD_LANES; i++) begin
            x = row.a[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH];
            y = row.b[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH];
            case (row.op)
                OP_ADD:  r = x + y;
                OP_SUB:  r = x - y;
                OP_AND:  r = x & y;
                default: r = x | y;
            endcase
            if (!row.mask[i]) begin
                r = '0;
            end
            row.exp_result[i*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH] = r;
            row.exp_zero[i] = row.mask[i] && (r == '0);
        end
        return row;
    endfunction

    task automatic add_row(input alu_op_t o, input lane_mask_t m,
                           input packed_word_t x, input packed_word_t y);
        stim_row_t row;
        row      = '0;
        row.op   = o;
        row.mask = m;
        row.a    = x;
        row.b    = y;
        stim_table.push_back(apply_reference(row));
    endtask

    task automatic drive_row(input stim_row_t row);
        in_valid   <= 1'b1;
        op         <= row.op;
        lane_mask  <= row.mask;
        a          <= row.a;
        b          <= row.b;
        exp_valid  <= 1'b1;
        exp_result <= row.exp_result;
        exp_zero   <= row.exp_zero;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] o_bits;
        logic [31:0] m_bits;
        logic [31:0] a_bits;
        logic [31:0] b_bits;
        int          waited;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        op         = '0;
        lane_mask  = '0;
        a          = '0;
        b          = '0;
        exp_valid  = 1'b0;
        exp_result = '0;
        exp_zero   = '0;
        summary    = 1'b0;
        lfsr_state = 16'd21917;

        // wraparound adds, ff + 01 and 80 + 80 give zero
        add_row(OP_ADD, 4'hF, 32'h7F01_80FF, 32'h0101_7F01);
        add_row(OP_ADD, 4'hF, 32'hFF80_0000, 32'h0180_0000);
        // equal operands and borrow through zero
        add_row(OP_SUB, 4'hF, 32'h5500_10FF, 32'h5501_20FF);
        add_row(OP_SUB, 4'hF, 32'h0180_7F00, 32'hFF01_8001);
        add_row(OP_AND, 4'hF, 32'hFFFF_AA55, 32'hF00F_FF55);
        add_row(OP_AND, 4'hF, 32'hAA55_0F0F, 32'h55AA_F0F0);
        add_row(OP_OR,  4'hF, 32'hAA55_0000, 32'h55AA_0000);
        add_row(OP_OR,  4'hF, 32'h0102_0408, 32'h1020_4080);
        // masked lanes, including an all-zero mask
        add_row(OP_ADD, 4'h5, 32'hFFFF_FFFF, 32'h0101_0101);
        add_row(OP_ADD, 4'h0, 32'h0000_0000, 32'h0000_0000);
        add_row(OP_SUB, 4'h8, 32'h3333_3333, 32'h3333_3333);

        for (int k = 0; k < NUM_RANDOM; k++) begin
            draw_bits(2, o_bits);
            draw_bits(`SIMD_LANES, m_bits);
            draw_bits(32, a_bits);
            draw_bits(32, b_bits);
            add_row(o_bits[1:0], m_bits[`SIMD_LANES-1:0], a_bits, b_bits);
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // out_valid must stay low before the first operation
        repeat (4) @(posedge clk);

        for (int k = 0; k < stim_table.size(); k++) begin
            drive_row(stim_table[k]);
            // a bubble now and then in the random part
            if (k >= NUM_FIXED && k % 7 == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();

        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end

        summary <= 1'b1;
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/simd_alu_pkg.sv
logic/lane_bus_if.sv
logic/brent_kung_adder.sv
logic/alu_lane.sv
logic/operand_dispatch.sv
logic/result_collect.sv
logic/simd_alu_top.sv
sim/simd_alu_checker.sv
sim/simd_alu_tb.sv
